/* source/cnn_macros.svh */
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// ----------------------------------------------------------
// image and memory geometry
// ----------------------------------------------------------
`define CNN_IMG_W 64 // image side, also layer-0 side
`define CNN_PIX_W 20 // pixel and memory data width
`define CNN_ADDR_W 12 // memory address width

// ----------------------------------------------------------
// arithmetic widths
// ----------------------------------------------------------
`define CNN_COEF_W 24 // transformed kernel coefficient
`define CNN_ACC_W 40 // products and sums
`define CNN_FRAC_W 20 // fraction bits dropped when rounding

// channel select codes on the layer memory bus
`define CNN_SEL_W 3
`define CNN_SEL_L0 3'd1 // conv output, 64x64
`define CNN_SEL_L1 3'd3 // pooled output, 32x32

`endif

/* source/cnnMemPkg.sv */
`include "cnn_macros.svh"

// memory-side view of the layer: what travels on the buses
package cnnMemPkg;

	typedef logic [`CNN_PIX_W-1:0] pixel_t; // unsigned pixel / memory word
	typedef logic [`CNN_ADDR_W-1:0] addr_t;
	typedef logic [`CNN_SEL_W-1:0] memSel_t; // channel code

	// one write to a layer memory, valid when en is high
	typedef struct packed {
		logic en;
		memSel_t sel;
		addr_t addr;
		pixel_t data;
	} memWrite_t;

	// one read, data comes back at the end of the same cycle
	typedef struct packed {
		logic en;
		memSel_t sel;
		addr_t addr;
	} memRead_t;

endpackage

/* source/winogradPkg.sv */
`include "cnn_macros.svh"

// arithmetic-side view: tiles, accumulators, kernel
package winogradPkg;

	typedef logic signed [`CNN_PIX_W-1:0] tileVal_t; // one tile element
	typedef tileVal_t [15:0] tile_t; // 4x4 tile, row-major, [0] top-left
	typedef logic signed [`CNN_ACC_W-1:0] acc_t;
	typedef logic signed [`CNN_COEF_W-1:0] coef_t;
	typedef cnnMemPkg::pixel_t [3:0] quad_t; // 2x2 outputs, row-major

	// ----------------------------------------------------------
	// kernel already in the Winograd domain, G g Gt
	// ----------------------------------------------------------
	localparam coef_t KERNEL [16] = '{
		24'h0A89E0,
		24'h0D45B0,
		24'h041860,
		24'h06D430,
		24'h02FBC8,
		24'hFF468C,
		24'hFFF2BC,
		24'hFC3D80,
		24'h01FB88,
		24'h06D844,
		24'h007B84,
		24'h055840,
		24'hFA6D70,
		24'hF8D920,
		24'hFC55E0,
		24'hFAC190
	};

	localparam tileVal_t BIAS = 20'h01310; // same fixed point as a pixel

endpackage

/* source/tileLoader.sv */
`include "cnn_macros.svh"

module tileLoader (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic nextTile,
	output cnnMemPkg::addr_t iaddr,
	input  cnnMemPkg::pixel_t idata,
	output logic tileValid,
	output winogradPkg::tile_t tile,
	output logic [5:0] tileRow,
	output logic [5:0] tileCol,
	output logic convDone
);
	import cnnMemPkg::*;
	import winogradPkg::*;

	localparam logic [5:0] lastPos = 6'(`CNN_IMG_W - 2); // origin of the last tile

	typedef enum logic [1:0] {sIdle, sLoad, sHold} state_t;

	state_t state;
	logic [4:0] reqIdx; // pixel being addressed, 16 = drain last one
	logic [3:0] capIdx; // pixel whose data is on idata now
	logic padCur; // pixel on the bus is padding
	logic [6:0] pixRow, pixCol;
	logic inImg;
	logic lastTile;

	// tile covers origin-1 .. origin+2; -1 and 64 both land >= 64 here
	assign pixRow = {1'b0, tileRow} + 7'(reqIdx[3:2]) - 7'd1;
	assign pixCol = {1'b0, tileCol} + 7'(reqIdx[1:0]) - 7'd1;
	assign inImg = (pixRow < 7'(`CNN_IMG_W)) && (pixCol < 7'(`CNN_IMG_W));
	assign capIdx = reqIdx[3:0] - 4'd1; // wraps to 15 on the drain step
	assign lastTile = (tileRow == lastPos) && (tileCol == lastPos);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= sIdle;
			reqIdx <= '0;
			padCur <= 1'b0;
			iaddr <= '0;
			tileRow <= '0;
			tileCol <= '0;
			tileValid <= 1'b0;
			convDone <= 1'b0;
		end else begin
			tileValid <= 1'b0;
			convDone <= 1'b0;
			case (state)
				sIdle: if (start) begin
					tileRow <= '0;
					tileCol <= '0;
					reqIdx <= '0;
					state <= sLoad;
				end
				sLoad: begin
					if (!reqIdx[4]) begin
						padCur <= !inImg;
						if (inImg) // padding keeps the bus quiet
							iaddr <= addr_t'({pixRow[5:0], pixCol[5:0]});
						reqIdx <= reqIdx + 5'd1;
					end else begin
						tileValid <= 1'b1;
						state <= sHold;
					end
				end
				sHold: if (nextTile) begin // quad is written, move on
					reqIdx <= '0;
					if (lastTile) begin
						convDone <= 1'b1;
						state <= sIdle;
					end else begin
						tileCol <= tileCol + 6'd2; // wraps to 0 past the edge
						if (tileCol == lastPos)
							tileRow <= tileRow + 6'd2;
						state <= sLoad;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// capture lags the address by one step
	always_ff @(posedge clk) begin
		if (state == sLoad && reqIdx != 5'd0)
			tile[capIdx] <= padCur ? '0 : tileVal_t'(idata);
	end

	addrOnlyWhileLoading: assert property (@(posedge clk) disable iff (reset)
		!$stable(iaddr) |-> $past(state) == sLoad)
		else $error("iaddr moved outside a tile fetch");

endmodule

/* source/winogradEngine.sv */
`include "cnn_macros.svh"

module winogradEngine (
	input  logic clk,
	input  logic reset,
	input  logic tileValid,
	input  winogradPkg::tile_t tile,
	output logic quadValid,
	output winogradPkg::quad_t quad
);
	import cnnMemPkg::*;
	import winogradPkg::*;

	// Y = At [ (G g Gt) .* (Bt d B) ] A
	tileVal_t xfA [16]; // Bt d
	tileVal_t xfB [16]; // Bt d B
	acc_t prod [16]; // elementwise with the kernel
	acc_t part [8]; // At applied to rows
	acc_t sums [4]; // finished 2x2, before ReLU
	acc_t biasAcc;
	logic [4:0] validPipe; // one bit per stage

	assign biasAcc = acc_t'(BIAS) <<< `CNN_FRAC_W; // bias up to product scale

	// negative -> 0, else drop fraction and round half up
	function automatic pixel_t reluRound(acc_t v);
		if (v < 0)
			return '0;
		return v[`CNN_ACC_W-1:`CNN_FRAC_W] + pixel_t'(v[`CNN_FRAC_W-1]);
	endfunction

	// ----------------------------------------------------------
	// datapath, free running; validPipe says what is real
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		// stage 1: combine tile rows
		for (int j = 0; j < 4; j++) begin
			xfA[j] <= tile[j] - tile[8+j];
			xfA[4+j] <= tile[4+j] + tile[8+j];
			xfA[8+j] <= tile[8+j] - tile[4+j];
			xfA[12+j] <= tile[4+j] - tile[12+j];
		end
		// stage 2: same pattern along each row
		for (int k = 0; k < 16; k += 4) begin
			xfB[k] <= xfA[k] - xfA[k+2];
			xfB[k+1] <= xfA[k+1] + xfA[k+2];
			xfB[k+2] <= xfA[k+2] - xfA[k+1];
			xfB[k+3] <= xfA[k+1] - xfA[k+3];
		end
		// stage 3
		for (int i = 0; i < 16; i++)
			prod[i] <= acc_t'(xfB[i]) * acc_t'(KERNEL[i]);
		// stage 4: fold four rows into two
		for (int j = 0; j < 4; j++) begin
			part[j] <= prod[j] + prod[4+j] + prod[8+j];
			part[4+j] <= prod[4+j] - prod[8+j] - prod[12+j];
		end
		// stage 5
		for (int q = 0; q < 4; q++)
			quad[q] <= reluRound(sums[q]);
	end

	always_comb begin
		sums[0] = part[0] + part[1] + part[2] + biasAcc;
		sums[1] = part[1] - part[2] - part[3] + biasAcc;
		sums[2] = part[4] + part[5] + part[6] + biasAcc;
		sums[3] = part[5] - part[6] - part[7] + biasAcc;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[3:0], tileValid};
	end

	assign quadValid = validPipe[4];

	fixedLatency: assert property (@(posedge clk) disable iff (reset)
		tileValid |-> ##5 quadValid)
		else $error("quad did not follow its tile by 5 cycles");

endmodule

/* source/maxPool.sv */
`include "cnn_macros.svh"

module maxPool (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output cnnMemPkg::memRead_t rd,
	input  cnnMemPkg::pixel_t cdataRd,
	output cnnMemPkg::memWrite_t wr,
	output logic done
);
	import cnnMemPkg::*;

	logic running;
	logic [2:0] step; // 0..3 read, 4 write
	logic [4:0] outX, outY; // layer-1 position
	logic [4:0] nextX, nextY;
	pixel_t maxVal, maxNext;

	assign maxNext = (step == 3'd0 || cdataRd > maxVal) ? cdataRd : maxVal;
	assign nextX = outX + 5'd1;
	assign nextY = (outX == 5'd31) ? outY + 5'd1 : outY;

	// k picks the pixel inside the 2x2 group, row-major
	function automatic memRead_t groupRead(logic [4:0] gy, logic [4:0] gx, logic [1:0] k);
		return '{en: 1'b1, sel: `CNN_SEL_L0, addr: {gy, k[1], gx, k[0]}};
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			step <= '0;
			outX <= '0;
			outY <= '0;
			rd <= '0;
			wr <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!running) begin
				if (start) begin
					running <= 1'b1;
					step <= '0;
					outX <= '0;
					outY <= '0;
					rd <= groupRead(5'd0, 5'd0, 2'd0);
				end
			end else if (step != 3'd4) begin
				if (step == 3'd3) begin // last data lands now, write it
					rd.en <= 1'b0;
					wr <= '{en: 1'b1, sel: `CNN_SEL_L1, addr: {2'b00, outY, outX},
						data: maxNext};
				end else
					rd <= groupRead(outY, outX, step[1:0] + 2'd1);
				step <= step + 3'd1;
			end else begin
				wr.en <= 1'b0;
				step <= '0;
				outX <= nextX;
				outY <= nextY;
				if (outX == 5'd31 && outY == 5'd31) begin
					running <= 1'b0;
					done <= 1'b1;
				end else
					rd <= groupRead(nextY, nextX, 2'd0);
			end
		end
	end

	// running max of the group
	always_ff @(posedge clk) begin
		if (running && step != 3'd4)
			maxVal <= maxNext;
	end

	oneAccessPerCycle: assert property (@(posedge clk) disable iff (reset)
		!(rd.en && wr.en))
		else $error("read and write issued together");

endmodule

/* source/cnnLayer.sv */
`include "cnn_macros.svh"

module cnnLayer (
	input  logic clk,
	input  logic reset,
	input  logic ready,
	output logic busy,
	output cnnMemPkg::addr_t iaddr,
	input  cnnMemPkg::pixel_t idata,
	output cnnMemPkg::memWrite_t layerWr,
	output cnnMemPkg::memRead_t layerRd,
	input  cnnMemPkg::pixel_t cdataRd
);
	import cnnMemPkg::*;
	import winogradPkg::*;

	typedef enum logic [1:0] {phIdle, phConv, phPool} phase_t;

	phase_t phase;
	logic convStart, convDone, poolStart, poolDone;
	logic tileValid, quadValid, nextTile;
	tile_t tile;
	quad_t quad, quadHold;
	logic [5:0] tileRow, tileCol; // origin of the tile in flight
	logic seqActive;
	logic [1:0] seqIdx; // next quad element to write
	memWrite_t l0Wr, poolWr;

	assign convStart = (phase == phIdle) && ready;
	assign poolStart = (phase == phConv) && convDone;
	assign layerWr = (phase == phPool) ? poolWr : l0Wr; // one writer per phase

	// quad element idx goes to (row + idx[1], col + idx[0])
	function automatic memWrite_t l0Write(logic [1:0] idx, pixel_t val);
		return '{en: 1'b1, sel: `CNN_SEL_L0,
			addr: {tileRow + 6'(idx[1]), tileCol + 6'(idx[0])}, data: val};
	endfunction

	tileLoader loader (.clk, .reset, .start(convStart), .nextTile, .iaddr, .idata,
		.tileValid, .tile, .tileRow, .tileCol, .convDone);

	winogradEngine engine (.clk, .reset, .tileValid, .tile, .quadValid, .quad);

	maxPool pool (.clk, .reset, .start(poolStart), .rd(layerRd), .cdataRd,
		.wr(poolWr), .done(poolDone));

	// ----------------------------------------------------------
	// phase and busy
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= phIdle;
			busy <= 1'b0;
		end else begin
			case (phase)
				phIdle: if (ready) begin
					phase <= phConv;
					busy <= 1'b1;
				end
				phConv: if (convDone) phase <= phPool;
				phPool: if (poolDone) begin
					phase <= phIdle;
					busy <= 1'b0;
				end
				default: phase <= phIdle;
			endcase
		end
	end

	// ----------------------------------------------------------
	// layer-0 writes, four cycles per quad
	// ----------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			l0Wr <= '0;
			seqActive <= 1'b0;
			seqIdx <= '0;
			nextTile <= 1'b0;
		end else begin
			nextTile <= 1'b0;
			if (quadValid) begin
				l0Wr <= l0Write(2'd0, quad[0]);
				seqActive <= 1'b1;
				seqIdx <= 2'd1;
			end else if (seqActive) begin
				if (seqIdx == 2'd0) begin // wrapped, all four out
					l0Wr.en <= 1'b0;
					seqActive <= 1'b0;
					nextTile <= 1'b1;
				end else begin
					l0Wr <= l0Write(seqIdx, quadHold[seqIdx]);
					seqIdx <= seqIdx + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (quadValid)
			quadHold <= quad; // engine moves on next cycle
	end

	quietWhenIdle: assert property (@(posedge clk) disable iff (reset)
		phase == phIdle |-> !layerWr.en)
		else $error("layer write while idle");

endmodule

/* bench/cnnBench.sv */
`include "cnn_macros.svh"

module cnnBench;
	timeunit 1ns;
	timeprecision 100ps;

	import cnnMemPkg::*;
	import winogradPkg::*;

	localparam int l0Size = `CNN_IMG_W * `CNN_IMG_W;
	localparam int l1Size = l0Size / 4; // 32x32 after pooling
	localparam pixel_t zeroImageOut = 20'h01310; // only the bias survives, fraction 0
	localparam pixel_t reluCeiling = 20'h80000; // top of a rounded non-negative sum

	logic clk, reset, ready, busy;
	addr_t iaddr;
	pixel_t idata, cdataRd;
	memWrite_t layerWr;
	memRead_t layerRd;

	pixel_t image [l0Size];
	pixel_t layer0 [l0Size];
	pixel_t layer1 [l1Size];
	int l0Cnt [l0Size]; // writes seen per address
	int l1Cnt [l1Size];
	int l0Writes, l1Writes;
	logic clearMem; // wipes the layer models between runs
	logic imageZero;
	logic [31:0] lfsr;

	cnnLayer dut (.clk, .reset, .ready, .busy, .iaddr, .idata, .layerWr, .layerRd, .cdataRd);

	// memories answer while the address is up
	assign idata = image[iaddr];
	assign cdataRd = layer0[layerRd.addr];

	// ----------------------------------------------------------
	// failure reporting
	// ----------------------------------------------------------
	task automatic abortRun();
		$display("=== FAIL ===");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic valueError(string msg);
		$display("ERR %0t ns %s", $time, msg);
		abortRun();
	endtask

	task automatic hangError(string what);
		$display("timeout at %0t ns, %s", $time, what);
		abortRun();
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic fillImage(logic zero);
		pixel_t pix;
		for (int a = 0; a < l0Size; a++) begin
			pix = '0;
			if (!zero)
				for (int b = 0; b < `CNN_PIX_W; b++) begin
					lfsr = lfsrStep(lfsr); // one step per bit
					pix = {pix[`CNN_PIX_W-2:0], lfsr[31]};
				end
			image[a] = pix;
		end
		imageZero = zero;
	endtask

	// max over the 2x2 group of layer 0 under pooled (y, x)
	function automatic pixel_t groupMax(int y, int x);
		pixel_t m;
		int a;
		m = '0;
		for (int k = 0; k < 4; k++) begin
			a = (2 * y + k / 2) * `CNN_IMG_W + 2 * x + k % 2;
			if (layer0[a] > m)
				m = layer0[a];
		end
		return m;
	endfunction

	// ----------------------------------------------------------
	// layer memory model with per-write checks
	// ----------------------------------------------------------
	always @(posedge clk) begin
		if (clearMem) begin
			for (int a = 0; a < l0Size; a++) begin
				layer0[a] = '0;
				l0Cnt[a] = 0;
			end
			for (int a = 0; a < l1Size; a++) begin
				layer1[a] = '0;
				l1Cnt[a] = 0;
			end
			l0Writes = 0;
			l1Writes = 0;
		end else if (layerWr.en) begin
			if (layerWr.sel == `CNN_SEL_L0) begin
				assert (l0Cnt[layerWr.addr] == 0)
					else valueError($sformatf("layer-0 addr %0d written twice", layerWr.addr));
				assert (layerWr.data <= reluCeiling) // wrapped negatives land above this
					else valueError($sformatf("layer-0 value %h out of ReLU range", layerWr.data));
				assert (!imageZero || layerWr.data == zeroImageOut)
					else valueError($sformatf("zero image gave %h, want %h", layerWr.data,
						zeroImageOut));
				layer0[layerWr.addr] = layerWr.data;
				l0Cnt[layerWr.addr]++;
				l0Writes++;
			end else if (layerWr.sel == `CNN_SEL_L1) begin
				assert (layerWr.addr < l1Size)
					else valueError($sformatf("layer-1 addr %0d out of range", layerWr.addr));
				assert (l1Cnt[layerWr.addr] == 0)
					else valueError($sformatf("layer-1 addr %0d written twice", layerWr.addr));
				assert (layerWr.data == groupMax(int'(layerWr.addr) / 32, int'(layerWr.addr) % 32))
					else valueError($sformatf("layer-1 addr %0d got %h, group max is %h",
						layerWr.addr, layerWr.data,
						groupMax(int'(layerWr.addr) / 32, int'(layerWr.addr) % 32)));
				layer1[layerWr.addr] = layerWr.data;
				l1Cnt[layerWr.addr]++;
				l1Writes++;
			end else
				valueError($sformatf("write with unknown sel %0d", layerWr.sel));
		end
	end

	// ----------------------------------------------------------
	// protocol checks
	// ----------------------------------------------------------
	idleQuiet: assert property (@(posedge clk) disable iff (reset)
		!busy |-> !layerWr.en && !layerRd.en)
		else valueError("layer bus active while not busy");

	imageQuiet: assert property (@(posedge clk) disable iff (reset)
		!busy |-> $stable(iaddr))
		else valueError("image address moved while not busy");

	startRaisesBusy: assert property (@(posedge clk) disable iff (reset)
		ready && !busy |=> busy)
		else valueError("busy did not rise after ready");

	convBeforePool: assert property (@(posedge clk) disable iff (reset)
		layerRd.en |-> l0Writes == l0Size && layerRd.sel == `CNN_SEL_L0)
		else valueError("layer read before layer 0 was complete");

	busyEndsAfterPool: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> l1Writes == l1Size)
		else valueError("busy fell before all layer-1 writes");

	// polls on the falling edge, away from the drive edge
	task automatic waitBusy(logic level, int limit, string what);
		int n;
		n = 0;
		while (busy !== level) begin
			if (n == limit)
				hangError(what);
			@(negedge clk);
			n++;
		end
	endtask

	task automatic runLayer(logic zero);
		int zeros;
		int positives;
		fillImage(zero);
		@(posedge clk);
		clearMem <= 1'b1;
		@(posedge clk);
		clearMem <= 1'b0;
		ready <= 1'b1; // one-cycle start pulse
		@(posedge clk);
		ready <= 1'b0;
		@(negedge clk);
		waitBusy(1'b1, 4, "busy never rose after ready");
		waitBusy(1'b0, 100000, "layer run never finished");
		zeros = 0;
		positives = 0;
		for (int a = 0; a < l0Size; a++) begin
			assert (l0Cnt[a] == 1)
				else valueError($sformatf("layer-0 addr %0d written %0d times", a, l0Cnt[a]));
			if (layer0[a] == '0)
				zeros++;
			else
				positives++;
		end
		for (int a = 0; a < l1Size; a++)
			assert (l1Cnt[a] == 1)
				else valueError($sformatf("layer-1 addr %0d written %0d times", a, l1Cnt[a]));
		if (!zero)
			assert (zeros > 0 && positives > 0)
				else valueError("random image never hit both ReLU branches");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		ready = 1'b0;
		clearMem = 1'b0;
		imageZero = 1'b1;
		lfsr = 32'hf38e;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!busy && !layerWr.en && !layerRd.en)
			else valueError("busy or an enable high after reset");
		runLayer(1'b1); // all-zero image, output is the bias
		runLayer(1'b0); // lfsr image
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+source
source/cnnMemPkg.sv
source/winogradPkg.sv
source/tileLoader.sv
source/winogradEngine.sv
source/maxPool.sv
source/cnnLayer.sv
bench/cnnBench.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing
TOP       := cnnBench
FILELIST  := filelist.f
OBJDIR    := obj_dir
PASSMSG   := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee /dev/stderr | grep -qF -- "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
